//--- verilog/pce_host_pkg.sv
/* Shared sizes, CD message kinds and the pad, loader, CD link and audio types
   used across the PC Engine host glue */
package pce_host_pkg;

	// ============================================================
	// Sizes and message kinds
	// ============================================================
	localparam int PAD_PORTS    = 5;
	localparam int PAD_BITS     = 12;
	localparam int SAMPLE_BITS  = 16;
	localparam int MIX_BITS     = 18;
	localparam int CD_COMM_BITS = 96;
	localparam int CD_DOUT_BITS = 80;
	localparam int CHEAT_WORDS  = 8;

	localparam logic [15:0] CD_KIND_DOUT     = 16'h0001;
	localparam logic [15:0] CD_KIND_DATA_END = 16'h0002;
	localparam logic [15:0] CD_KIND_RESET    = 16'h00FF;

	// ============================================================
	// Pads and loader
	// ============================================================

	// Active high, as delivered by the host
	typedef struct packed {
		logic [3:0] ext_btn;    // III, IV, V, VI from bit 8
		logic [3:0] btn;        // I, II, select, run from bit 4
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} pad_word_t;

	typedef struct packed {
		logic clr;
		logic sel;
	} pad_ctrl_t;

	typedef struct packed {
		logic turbo_tap;
		logic six_button;
		logic fast_seek;
	} host_cfg_t;

	typedef struct packed {
		logic        wr;
		logic        code_sel;
		logic [3:0]  addr;
		logic [15:0] data;
	} loader_write_t;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// ============================================================
	// CD host link and audio
	// ============================================================

	// Host reads the payload as a command or as a data-out block
	typedef union packed {
		logic [CD_COMM_BITS-1:0] comm;
		struct packed {
			logic [CD_COMM_BITS-CD_DOUT_BITS-1:0] pad;
			logic [CD_DOUT_BITS-1:0]              data;
		} dout;
	} cd_payload_u;

	typedef struct packed {
		logic        toggle;
		logic [15:0] kind;
		cd_payload_u payload;
	} cd_host_word_t;

	typedef struct packed {
		logic                    comm_send;
		logic                    dout_send;
		logic                    data_end;
		logic                    cd_reset;
		logic [CD_COMM_BITS-1:0] comm;
		logic [CD_DOUT_BITS-1:0] dout;
	} cd_core_req_t;

	typedef struct packed {
		logic [7:0] msg;
		logic [7:0] stat;
	} cd_status_t;

	typedef struct packed {
		logic signed [SAMPLE_BITS-1:0] cdda_l;
		logic signed [SAMPLE_BITS-1:0] cdda_r;
		logic signed [SAMPLE_BITS-1:0] psg_l;
		logic signed [SAMPLE_BITS-1:0] psg_r;
		logic signed [SAMPLE_BITS-1:0] adpcm;
	} audio_src_t;

	typedef struct packed {
		logic signed [SAMPLE_BITS-1:0] left;
		logic signed [SAMPLE_BITS-1:0] right;
	} audio_out_t;

endpackage

//--- verilog/pad_mux.sv
/* Joypad multiplexer: multitap port walk, six-button bank and nibble latch */
`timescale 1ns/1ns

module pad_mux (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  pce_host_pkg::pad_word_t pads [pce_host_pkg::PAD_PORTS],
	input  pce_host_pkg::pad_ctrl_t pad_ctrl,
	input  logic                  turbo_tap,
	input  logic                  six_button,
	output logic [3:0]            pad_nibble
);

	logic [2:0]              port;
	logic                    bank;
	pce_host_pkg::pad_ctrl_t ctrl_d;
	pce_host_pkg::pad_word_t cur_pad;
	logic                    port_valid;
	logic [15:0]             read_word;
	logic [3:0]              nibble;

	// ============================================================
	// Read word of the selected port
	// ============================================================
	always_comb begin
		cur_pad = '0;
		for (int i = 0; i < pce_host_pkg::PAD_PORTS; i++) begin
			if (port == 3'(i)) begin
				cur_pad = pads[i];
			end
		end
	end

	assign port_valid = port < 3'(pce_host_pkg::PAD_PORTS);

	// Pad lines are active low; directions up, right, down, left from bit 4
	always_comb begin
		if (port_valid) begin
			read_word = ~{4'hF, cur_pad.ext_btn,
				cur_pad.left, cur_pad.down, cur_pad.right, cur_pad.up,
				cur_pad.btn};
		end else begin
			// Missing tap ports read as released
			read_word = {4'h0, {pce_host_pkg::PAD_BITS{1'b1}}};
		end
	end

	// Bank 1 exposes buttons III..VI with sel low
	assign nibble = read_word[{bank, pad_ctrl.sel, 2'b00} +: 4];

	// ============================================================
	// Port counter, bank and latch
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port       <= '0;
			bank       <= 1'b0;
			ctrl_d     <= '0;
			pad_nibble <= '0;
		end else begin
			ctrl_d     <= pad_ctrl;
			pad_nibble <= nibble;

			if (pad_ctrl.clr) begin
				port       <= '0;
				pad_nibble <= '0;
				// Six-button pads alternate banks on each clr pulse
				if (!ctrl_d.clr) begin
					bank <= ~bank && six_button;
				end
			end else if (pad_ctrl.sel && !ctrl_d.sel && turbo_tap) begin
				port <= port + 3'd1;
			end
		end
	end

endmodule

//--- verilog/cd_link.sv
/* CD host message link: toggle-bit requests towards the host and
   status or data-out requests coming back */
`timescale 1ns/1ns

module cd_link (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        fast_seek,
	input  pce_host_pkg::cd_core_req_t  cd_req,
	input  pce_host_pkg::cd_host_word_t host_in,
	output pce_host_pkg::cd_host_word_t host_out,
	output pce_host_pkg::cd_status_t    cd_stat,
	output logic                        stat_get,
	output logic                        dout_req
);

	logic [3:0] req_now;
	logic [3:0] req_prev;
	logic [3:0] req_rise;
	logic       host_toggle_d;

	// Order is priority: comm, dout, data end, reset
	assign req_now  = {cd_req.comm_send, cd_req.dout_send, cd_req.data_end, cd_req.cd_reset};
	assign req_rise = req_now & ~req_prev;

	// ============================================================
	// Core to host
	// ============================================================
	always_ff @(posedge clk_sys) begin
		// Tracked through reset so a held request is not seen as new
		req_prev <= req_now;

		if (reset) begin
			host_out <= '0;
		end else begin
			if (req_rise[3]) begin
				host_out.payload.comm <= cd_req.comm;
				host_out.kind         <= {fast_seek, 15'd0};
				host_out.toggle       <= ~host_out.toggle;
			end else if (req_rise[2]) begin
				// Upper payload bits keep their last value
				host_out.payload.dout.data <= cd_req.dout;
				host_out.kind              <= pce_host_pkg::CD_KIND_DOUT;
				host_out.toggle            <= ~host_out.toggle;
			end else if (req_rise[1]) begin
				host_out.kind   <= pce_host_pkg::CD_KIND_DATA_END;
				host_out.toggle <= ~host_out.toggle;
			end else if (req_rise[0]) begin
				host_out.kind   <= pce_host_pkg::CD_KIND_RESET;
				host_out.toggle <= ~host_out.toggle;
			end
		end
	end

	// ============================================================
	// Host to core
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			host_toggle_d <= host_in.toggle;
			stat_get      <= 1'b0;
			dout_req      <= 1'b0;
		end else begin
			stat_get <= 1'b0;
			dout_req <= 1'b0;
			if (host_in.toggle != host_toggle_d) begin
				host_toggle_d <= host_in.toggle;
				// Bit 16 marks a request for the next data-out block
				stat_get <= ~host_in.payload.comm[16];
				dout_req <= host_in.payload.comm[16];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (host_in.toggle != host_toggle_d) begin
			cd_stat <= host_in.payload.comm[15:0];
		end
	end

	// Status and data-out requests come from distinct host messages
	stat_dout_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(stat_get && dout_req))
		else $error("stat_get and dout_req high together");

	// The host sees a new message only after a core request edge
	toggle_needs_req: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(host_out.toggle) |-> $past(|req_rise))
		else $error("host_out toggle changed without a request edge");

endmodule

//--- verilog/cheat_loader.sv
/* Cheat-code loader: assembles a code from eight 16-bit writes */
`timescale 1ns/1ns

module cheat_loader (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  pce_host_pkg::loader_write_t ldr,
	output pce_host_pkg::cheat_code_t   cheat,
	output logic                        cheat_load
);

	logic code_wr;
	logic last_word;

	assign code_wr   = ldr.wr && ldr.code_sel;
	// Final word of a code sits at byte address 14
	assign last_word = ldr.addr == 4'((pce_host_pkg::CHEAT_WORDS - 1) * 2);

	// ============================================================
	// Word assembly, low half first for each field
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ldr.addr)
				4'd0:  cheat.flags[15:0]    <= ldr.data;
				4'd2:  cheat.flags[31:16]   <= ldr.data;
				4'd4:  cheat.addr[15:0]     <= ldr.data;
				4'd6:  cheat.addr[31:16]    <= ldr.data;
				4'd8:  cheat.compare[15:0]  <= ldr.data;
				4'd10: cheat.compare[31:16] <= ldr.data;
				4'd12: cheat.replace[15:0]  <= ldr.data;
				4'd14: cheat.replace[31:16] <= ldr.data;
				default: ;
			endcase
		end
	end

	// Load strobe follows the last word by one cycle
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_load <= 1'b0;
		end else begin
			cheat_load <= code_wr && last_word;
		end
	end

	// One code per strobe
	load_single: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_load |=> !cheat_load)
		else $error("cheat_load held for two cycles");

endmodule

//--- verilog/audio_mix.sv
/* Stereo mixer for CD audio, PSG and ADPCM with 5/4 output gain */
`timescale 1ns/1ns

module audio_mix (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  pce_host_pkg::audio_src_t audio_src,
	output pce_host_pkg::audio_out_t audio_out
);

	logic signed [pce_host_pkg::MIX_BITS-1:0] pre_l;
	logic signed [pce_host_pkg::MIX_BITS-1:0] pre_r;
	logic signed [pce_host_pkg::MIX_BITS-1:0] post_l;
	logic signed [pce_host_pkg::MIX_BITS-1:0] post_r;

	// ============================================================
	// Sum, then scale by 1 + 1/4
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pre_l  <= '0;
			pre_r  <= '0;
			post_l <= '0;
			post_r <= '0;
		end else begin
			// Two guard bits hold the three-way sum
			pre_l <= pce_host_pkg::MIX_BITS'(audio_src.cdda_l)
				+ pce_host_pkg::MIX_BITS'(audio_src.psg_l)
				+ pce_host_pkg::MIX_BITS'(audio_src.adpcm);
			pre_r <= pce_host_pkg::MIX_BITS'(audio_src.cdda_r)
				+ pce_host_pkg::MIX_BITS'(audio_src.psg_r)
				+ pce_host_pkg::MIX_BITS'(audio_src.adpcm);

			post_l <= pre_l + (pre_l >>> 2);
			post_r <= pre_r + (pre_r >>> 2);
		end
	end

	// Drop the two low bits back to sample width
	assign audio_out.left  = post_l[pce_host_pkg::MIX_BITS-1:2];
	assign audio_out.right = post_r[pce_host_pkg::MIX_BITS-1:2];

endmodule

//--- verilog/pce_host_top.sv
/* Host-side glue top: pad multiplexer, cheat loader, CD link and mixer */
`timescale 1ns/1ns

module pce_host_top (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  pce_host_pkg::host_cfg_t     cfg,

	// Joypads
	input  pce_host_pkg::pad_word_t     pads [pce_host_pkg::PAD_PORTS],
	input  pce_host_pkg::pad_ctrl_t     pad_ctrl,
	output logic [3:0]                  pad_nibble,

	// Cheat loader
	input  pce_host_pkg::loader_write_t ldr,
	output pce_host_pkg::cheat_code_t   cheat,
	output logic                        cheat_load,

	// CD host link
	input  pce_host_pkg::cd_core_req_t  cd_req,
	input  pce_host_pkg::cd_host_word_t host_in,
	output pce_host_pkg::cd_host_word_t host_out,
	output pce_host_pkg::cd_status_t    cd_stat,
	output logic                        stat_get,
	output logic                        dout_req,

	// Audio
	input  pce_host_pkg::audio_src_t    audio_src,
	output pce_host_pkg::audio_out_t    audio_out
);

	pad_mux pad_mux_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pads       (pads),
		.pad_ctrl   (pad_ctrl),
		.turbo_tap  (cfg.turbo_tap),
		.six_button (cfg.six_button),
		.pad_nibble (pad_nibble)
	);

	cheat_loader cheat_loader_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ldr        (ldr),
		.cheat      (cheat),
		.cheat_load (cheat_load)
	);

	cd_link cd_link_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.fast_seek (cfg.fast_seek),
		.cd_req    (cd_req),
		.host_in   (host_in),
		.host_out  (host_out),
		.cd_stat   (cd_stat),
		.stat_get  (stat_get),
		.dout_req  (dout_req)
	);

	audio_mix audio_mix_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.audio_src (audio_src),
		.audio_out (audio_out)
	);

endmodule

//--- tb/pce_host_tb.sv
/* Testbench for the host glue top: pattern-driven pad, cheat and CD link tests,
   random mixer samples, per-test report and timeout */
`timescale 1ns/1ns

module pce_host_tb;

	localparam int MAX_RECORDS = 64;
	// Well above the roughly 150 cycles the patterns need
	localparam int CYCLE_LIMIT = 2000;

	logic                        clk_sys;
	logic                        reset;
	pce_host_pkg::host_cfg_t     cfg;
	pce_host_pkg::pad_word_t     pads [pce_host_pkg::PAD_PORTS];
	pce_host_pkg::pad_ctrl_t     pad_ctrl;
	logic [3:0]                  pad_nibble;
	pce_host_pkg::loader_write_t ldr;
	pce_host_pkg::cheat_code_t   cheat;
	logic                        cheat_load;
	pce_host_pkg::cd_core_req_t  cd_req;
	pce_host_pkg::cd_host_word_t host_in;
	pce_host_pkg::cd_host_word_t host_out;
	pce_host_pkg::cd_status_t    cd_stat;
	logic                        stat_get;
	logic                        dout_req;
	pce_host_pkg::audio_src_t    audio_src;
	pce_host_pkg::audio_out_t    audio_out;

	// Record fields test, op, cfg, arg and data
	logic [71:0] patterns [MAX_RECORDS];
	int          errors;
	int          cycles;
	int          seed;
	int          tests_passed;
	int          tests_failed;

	// Expected DUT state
	pce_host_pkg::cheat_code_t exp_cheat;
	logic [95:0]               exp_payload;
	logic                      exp_toggle;

	pce_host_top dut_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cfg        (cfg),
		.pads       (pads),
		.pad_ctrl   (pad_ctrl),
		.pad_nibble (pad_nibble),
		.ldr        (ldr),
		.cheat      (cheat),
		.cheat_load (cheat_load),
		.cd_req     (cd_req),
		.host_in    (host_in),
		.host_out   (host_out),
		.cd_stat    (cd_stat),
		.stat_get   (stat_get),
		.dout_req   (dout_req),
		.audio_src  (audio_src),
		.audio_out  (audio_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	// ============================================================
	// Checks and report
	// ============================================================
	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %0h, expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input int id, input int errors_before);
		if (errors == errors_before) begin
			$display("Test %0d passed", id);
			tests_passed++;
		end else begin
			$display("Test %0d failed with %0d errors", id, errors - errors_before);
			tests_failed++;
		end
	endtask

	// 5/4 gain with the two low bits dropped
	function automatic logic [15:0] scaled_sample(input int sum);
		int gained;
		gained = sum + (sum >>> 2);
		return 16'(gained >>> 2);
	endfunction

	// ============================================================
	// Stimulus tasks
	// ============================================================
	task automatic set_pad(input logic [2:0] port, input logic [11:0] buttons);
		@(posedge clk_sys);
		pads[port] <= buttons;
	endtask

	// Eight steps with clr in ctrl_bits 15:8, sel in 7:0 and nibble i at bit 4i
	task automatic run_pad_steps(input logic [7:0] cfg_bits, input logic [15:0] ctrl_bits,
		input logic [31:0] exp_nibbles);
		@(posedge clk_sys);
		cfg.turbo_tap  <= cfg_bits[2];
		cfg.six_button <= cfg_bits[1];
		pad_ctrl       <= {ctrl_bits[8], ctrl_bits[0]};
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			if (i < 7) begin
				pad_ctrl <= {ctrl_bits[9 + i], ctrl_bits[1 + i]};
			end
			@(negedge clk_sys);
			check_value($sformatf("pad_nibble step %0d", i), pad_nibble,
				exp_nibbles[4 * i +: 4]);
		end
	endtask

	task automatic write_loader(input logic code_sel, input logic [3:0] addr,
		input logic [15:0] data);
		@(posedge clk_sys);
		ldr <= {1'b1, code_sel, addr, data};
		if (code_sel) begin
			exp_cheat[96 - 32 * int'(addr[3:2]) + 16 * int'(addr[1]) +: 16] = data;
		end
		@(posedge clk_sys);
		ldr.wr <= 1'b0;
		@(negedge clk_sys);
		// Word at address 14 closes the code
		check_value("cheat_load", cheat_load, code_sel && addr == 4'd14);
		@(negedge clk_sys);
		check_value("cheat_load", cheat_load, 1'b0);
	endtask

	// req_bits 7:4 hold comm, dout, data end and reset
	// Bit 0 of req_bits is fast_seek
	task automatic send_request(input logic [7:0] req_bits, input logic [15:0] exp_kind,
		input logic [31:0] data);
		@(posedge clk_sys);
		cfg.fast_seek <= req_bits[0];
		{cd_req.comm_send, cd_req.dout_send, cd_req.data_end, cd_req.cd_reset} <= req_bits[7:4];
		cd_req.comm <= {3{data}};
		cd_req.dout <= {data[15:0], data, data};
		if (req_bits[7]) begin
			exp_payload = {3{data}};
		end else if (req_bits[6]) begin
			exp_payload[79:0] = {data[15:0], data, data};
		end
		exp_toggle = ~exp_toggle;
		@(posedge clk_sys);
		{cd_req.comm_send, cd_req.dout_send, cd_req.data_end, cd_req.cd_reset} <= 4'b0000;
		@(negedge clk_sys);
		check_value("host_out.toggle", host_out.toggle, exp_toggle);
		check_value("host_out.kind", host_out.kind, exp_kind);
		check_value("host_out.payload", host_out.payload, exp_payload);
		// Lower-priority edges of the same cycle are dropped
		@(negedge clk_sys);
		check_value("host_out.toggle", host_out.toggle, exp_toggle);
	endtask

	task automatic send_status(input logic dout_bit, input logic [15:0] status);
		@(posedge clk_sys);
		host_in.toggle             <= ~host_in.toggle;
		host_in.payload.comm[16:0] <= {dout_bit, status};
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("cd_stat", cd_stat, status);
		check_value("stat_get", stat_get, !dout_bit);
		check_value("dout_req", dout_req, dout_bit);
		@(negedge clk_sys);
		check_value("stat_get", stat_get, 1'b0);
		check_value("dout_req", dout_req, 1'b0);
	endtask

	// One sample set per cycle, each result two cycles later
	task automatic run_audio(input int count);
		pce_host_pkg::audio_src_t src;
		logic [31:0]              exp_q [$];
		logic [31:0]              exp;
		int                       sum_l;
		int                       sum_r;
		for (int i = 0; i < count + 2; i++) begin
			@(posedge clk_sys);
			if (i < count) begin
				src.cdda_l = 16'($random(seed));
				src.cdda_r = 16'($random(seed));
				src.psg_l  = 16'($random(seed));
				src.psg_r  = 16'($random(seed));
				src.adpcm  = 16'($random(seed));
				audio_src <= src;
				sum_l = int'($signed(src.cdda_l)) + int'($signed(src.psg_l))
					+ int'($signed(src.adpcm));
				sum_r = int'($signed(src.cdda_r)) + int'($signed(src.psg_r))
					+ int'($signed(src.adpcm));
				exp_q.push_back({scaled_sample(sum_l), scaled_sample(sum_r)});
			end
			@(negedge clk_sys);
			if (i >= 2) begin
				exp = exp_q.pop_front();
				check_value("audio_out.left", $unsigned(audio_out.left), exp[31:16]);
				check_value("audio_out.right", $unsigned(audio_out.right), exp[15:0]);
			end
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		int          rec;
		int          cur_test;
		int          test_errors;
		logic [7:0]  test_id;
		logic [7:0]  op;
		logic [7:0]  rec_cfg;
		logic [15:0] arg;
		logic [31:0] data;

		seed         = 66628;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		reset        = 1'b1;
		cfg          = '0;
		pad_ctrl     = '0;
		ldr          = '0;
		cd_req       = '0;
		host_in      = '0;
		audio_src    = '0;
		for (int i = 0; i < pce_host_pkg::PAD_PORTS; i++) begin
			pads[i] = '0;
		end
		exp_cheat   = '0;
		exp_payload = '0;
		exp_toggle  = 1'b0;
		$readmemh("tb/host_patterns.mem", patterns);

		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;

		cur_test    = 0;
		test_errors = 0;
		for (rec = 0; rec < MAX_RECORDS; rec++) begin
			if ($isunknown(patterns[rec]) || patterns[rec][63:56] == 8'hFF) begin
				break;
			end
			{test_id, op, rec_cfg, arg, data} = patterns[rec];
			if (int'(test_id) != cur_test) begin
				if (cur_test != 0) begin
					report_test(cur_test, test_errors);
				end
				cur_test    = int'(test_id);
				test_errors = errors;
			end
			case (op)
				8'h01: set_pad(rec_cfg[2:0], data[11:0]);
				8'h02: run_pad_steps(rec_cfg, arg, data);
				8'h03: begin
					write_loader(rec_cfg[0], arg[3:0], data[15:0]);
					write_loader(rec_cfg[0], arg[3:0] + 4'd2, data[31:16]);
				end
				8'h04: check_value("cheat", cheat, exp_cheat);
				8'h05: send_request(rec_cfg, arg, data);
				8'h06: send_status(rec_cfg[0], data[15:0]);
				8'h07: run_audio(int'(arg));
				default: begin
					$display("Pattern record %0d has an unknown op %0h", rec, op);
					errors++;
				end
			endcase
		end

		if (cur_test != 0) begin
			report_test(cur_test, test_errors);
		end else begin
			$display("No pattern records could be read from tb/host_patterns.mem");
			errors++;
		end

		$display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- tb/host_patterns.mem
// Columns: test _ op _ cfg _ arg _ data, op 01 pad, 02 pad steps, 03 cheat field,
// 04 cheat check, 05 CD request, 06 host status, 07 audio sets, FF end
01_01_00_0000_000003A6
01_01_01_0000_00000051
01_01_02_0000_000000F8
01_01_03_0000_00000024
01_01_04_0000_000000C2
01_02_00_30AA_35003535
02_02_04_01AA_BDE0DA30
02_02_04_104A_A350FF73
03_02_02_5104_C050C0C0
04_03_01_0000_0001C0DE
04_03_01_0004_0000F3A1
04_03_01_0008_000000AB
04_03_01_000C_000000CD
04_03_00_000C_FFFFFFFF
04_04_00_0000_00000000
05_05_81_8000_12345678
05_05_40_0001_9ABCDEF0
05_05_30_0002_00000000
05_05_10_00FF_00000000
05_06_00_0000_00005A3C
05_06_01_0000_0000C3A5
06_07_00_0020_00000000
00_FF_00_0000_00000000

//--- files.f
verilog/pce_host_pkg.sv
verilog/pad_mux.sv
verilog/cd_link.sv
verilog/cheat_loader.sv
verilog/audio_mix.sv
verilog/pce_host_top.sv
tb/pce_host_tb.sv

//--- Bender.yml
package:
  name: pce_host

sources:
  - verilog/pce_host_pkg.sv
  - verilog/pad_mux.sv
  - verilog/cd_link.sv
  - verilog/cheat_loader.sv
  - verilog/audio_mix.sv
  - verilog/pce_host_top.sv
  - target: simulation
    files:
      - tb/pce_host_tb.sv
